/* bench/correlator_model.sv */
/*
 * Reference model of the pulse correlator for the testbench.
 * The testbench calls apply_strobe with the enabled samples of each strobe
 * and restart on a clear; expected counters are then read by hierarchy.
 * Also holds the Galois LFSR that feeds the random stimulus.
 */

`include "correlator_consts.svh"

module correlator_model;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int COUNT_MAX = (1 << `RESOLUTION) - 1;

	logic [`NUM_LAGS-1:0] history [`NUM_INPUTS]; // bit 0 is the newest sample.
	int expected_count [`NUM_CORR];
	logic expected_sat [`NUM_CORR];
	logic [31:0] lfsr_state = 32'h8124_abc0;

	// ~~~~~~~~~~~~~~~~~~~~
	// random bits

	// one LFSR step per bit taken.
	function automatic logic [31:0] take_bits(input int count);
		logic out_bit;
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			out_bit = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (out_bit) lfsr_state = lfsr_state ^ 32'h8020_0003;
			bits = {bits[30:0], out_bit};
		end
		return bits;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// counters

	task automatic restart();
		for (int i = 0; i < `NUM_CORR; i++) begin
			expected_count[i] = 0;
			expected_sat[i] = 1'b0;
		end
	endtask

	task automatic apply_strobe(input logic [`NUM_INPUTS-1:0] loaded);
		int base;
		int idx;
		for (int ch = 0; ch < `NUM_INPUTS; ch++) begin
			history[ch] = {history[ch][`NUM_LAGS-2:0], loaded[ch]};
		end
		base = 0;
		for (int a = 0; a < `NUM_INPUTS - 1; a++) begin
			for (int b = a + 1; b < `NUM_INPUTS; b++) begin
				for (int lag = 0; lag < `NUM_LAGS; lag++) begin
					idx = base * `NUM_LAGS + lag;
					if (history[a][`LAG_CROSS-1] && history[b][lag]) begin
						if (expected_count[idx] == COUNT_MAX) expected_sat[idx] = 1'b1;
						else expected_count[idx]++;
					end
				end
				base++; // next baseline.
			end
		end
	endtask

	initial begin
		for (int ch = 0; ch < `NUM_INPUTS; ch++) history[ch] = '0;
		restart();
	end

endmodule

/* bench/correlator_tb.sv */
/*
 * Testbench for the pulse correlator.
 * Drives strobes 1 ns after each rising edge, keeps a reference model in
 * step, and checks every counter through the read port after each phase:
 * reset, a single pulse pair, random strobes, clear, and saturation.
 */

`include "correlator_consts.svh"

module correlator_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import correlator_pkg::*;

	localparam int RANDOM_STROBES = 300;
	localparam int CLEAR_STROBES = 100;
	localparam int SAT_STROBES = 4200;
	localparam int READ_CYCLES = 2 * (5 * `NUM_CORR + 32);
	localparam int STROBE_CYCLES = 2 * (RANDOM_STROBES + CLEAR_STROBES) + SAT_STROBES + 40;
	localparam int WATCHDOG_CYCLES = READ_CYCLES + STROBE_CYCLES + 1000;

	logic clk;
	logic reset;
	logic sample_strobe;
	logic [`NUM_INPUTS-1:0] samples;
	logic [`NUM_INPUTS-1:0] channel_enable;
	logic clear;
	logic [`ADDR_WIDTH-1:0] read_addr;
	read_word_t read_data;

	tb_clock tb_clock_i (.clk(clk));

	correlator_model model_i ();

	correlator_top correlator_top_i (
		.clk            (clk),
		.reset          (reset),
		.sample_strobe  (sample_strobe),
		.samples        (samples),
		.channel_enable (channel_enable),
		.clear          (clear),
		.read_addr      (read_addr),
		.read_data      (read_data)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// concurrent checks

	assert property (@(posedge clk) disable iff (!reset)
		read_data.saturated |-> read_data.count == corr_count_t'('1))
		else report_failure($sformatf("Mismatch read_data.count: got %h expected %h",
			read_data.count, corr_count_t'('1)));

	// past the last counter nothing is returned.
	assert property (@(posedge clk) disable iff (!reset)
		read_addr >= `ADDR_WIDTH'(`NUM_CORR) |=> read_data == '0)
		else report_failure($sformatf("Mismatch read_data: got %h expected %h",
			read_data, 13'h0));

	// ~~~~~~~~~~~~~~~~~~~~
	// stimulus

	task automatic drive_cycle(input logic strobe, input logic [`NUM_INPUTS-1:0] samp,
		input logic [`NUM_INPUTS-1:0] en);
		@(posedge clk);
		#1;
		sample_strobe = strobe;
		samples = samp;
		channel_enable = en;
		if (strobe) model_i.apply_strobe(samp & en);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) drive_cycle(1'b0, '0, channel_enable);
	endtask

	task automatic random_strobes(input int count);
		logic [31:0] bits;
		int done;
		done = 0;
		while (done < count) begin
			bits = model_i.take_bits(2);
			if (bits[1:0] != 2'b00) begin // about three cycles in four strobe.
				bits = model_i.take_bits(2 * `NUM_INPUTS);
				drive_cycle(1'b1, bits[`NUM_INPUTS-1:0], bits[2*`NUM_INPUTS-1:`NUM_INPUTS]);
				done++;
			end else begin
				drive_cycle(1'b0, '0, channel_enable);
			end
		end
	endtask

	task automatic pulse_clear();
		@(posedge clk);
		#1 clear = 1'b1;
		@(posedge clk);
		#1 clear = 1'b0;
		model_i.restart(); // history is kept.
	endtask

	task automatic read_check(input int addr);
		read_word_t expected;
		expected = '0;
		if (addr < `NUM_CORR) begin
			expected.count = corr_count_t'(model_i.expected_count[addr]);
			expected.saturated = model_i.expected_sat[addr];
		end
		@(posedge clk);
		#1 read_addr = `ADDR_WIDTH'(addr);
		@(posedge clk);
		#1;
		assert (read_data == expected)
			else report_failure($sformatf("Mismatch read_data at address %0d: got %h expected %h",
				addr, read_data, expected));
	endtask

	task automatic read_all();
		for (int addr = 0; addr < `NUM_CORR; addr++) read_check(addr);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// sequence

	initial begin
		reset = 1'b0;
		sample_strobe = 1'b0;
		samples = '0;
		channel_enable = '0;
		clear = 1'b0;
		read_addr = '0;
		repeat (4) @(posedge clk);
		#1 reset = 1'b1;

		read_all(); // counters start at zero.

		drive_cycle(1'b1, `NUM_INPUTS'(2'b11), '1); // channels 0 and 1 together.
		repeat (3) drive_cycle(1'b1, '0, '1);
		idle(4);
		read_all();

		random_strobes(RANDOM_STROBES);
		idle(4);
		read_all();

		pulse_clear();
		random_strobes(CLEAR_STROBES);
		idle(4);
		read_all();

		repeat (SAT_STROBES) drive_cycle(1'b1, '1, '1);
		idle(4);
		read_all();
		for (int addr = `NUM_CORR; addr < (1 << `ADDR_WIDTH); addr++) read_check(addr);

		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_failure("Watchdog expired before the test sequence finished.");
	end

endmodule

/* bench/tb_clock.sv */
/*
 * Free-running clock for the correlator testbench.
 * Period 20 ns, starting low.
 */

module tb_clock (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam realtime HALF_PERIOD = 10ns;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule

/* include/correlator_consts.svh */
/*
 * Size constants for the pulse correlator.
 * Included by the package and by every RTL module that sizes a port or a loop.
 * Derived values are built from the channel count and the lag half-width,
 * so only those two and the counter width need editing.
 */

`ifndef CORRELATOR_CONSTS_SVH
`define CORRELATOR_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// base sizes
`define NUM_INPUTS 4
`define LAG_CROSS 2
`define RESOLUTION 12
`define ADDR_WIDTH 5

// ~~~~~~~~~~~~~~~~~~~~
// derived sizes
`define NUM_LAGS (2 * `LAG_CROSS - 1) // taps per delay line as well.
`define CENTRE_TAP (`LAG_CROSS - 1) // zero-lag tap.
`define NUM_BASELINES (`NUM_INPUTS * (`NUM_INPUTS - 1) / 2)
`define NUM_CORR (`NUM_BASELINES * `NUM_LAGS)

`endif

/* run.sh */
#!/bin/sh
# Build the correlator testbench with Verilator and run it.
# The exit status is the simulator's, so a failing run returns non-zero.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module correlator_tb \
	-f src.f -o correlator_sim &&
./obj_dir/correlator_sim || exit 1

/* src.f */
+incdir+include
src/correlator_pkg.sv
src/lag_delay_line.sv
src/coincidence_stage.sv
src/correlation_accum.sv
src/readout_port.sv
src/correlator_top.sv
bench/tb_clock.sv
bench/correlator_model.sv
bench/correlator_tb.sv

/* src/coincidence_stage.sv */
/*
 * Coincidence stage of the pulse correlator.
 * For every baseline (a,b) with a<b and every lag c it forms the product
 * of the centre tap of channel a and tap LAG_CROSS-1+c of channel b.
 * One-bit samples make the product a plain AND.
 * All hit bits are registered together with the valid bit, one cycle
 * after the tap set arrives.
 */

`include "correlator_consts.svh"

module coincidence_stage (
	input  logic                      clk,
	input  logic                      reset,
	input  correlator_pkg::tap_set_t  tap_set,
	output correlator_pkg::product_t  products
);
	import correlator_pkg::*;

	product_t next_products;

	// ~~~~~~~~~~~~~~~~~~~~
	// baseline and lag walk

	genvar a, b, l;
	generate
		for (a = 0; a < `NUM_INPUTS - 1; a++) begin : g_chan_a
			for (b = a + 1; b < `NUM_INPUTS; b++) begin : g_chan_b
				// earlier rows of a plus offset in the row.
				localparam int BASE = a * (2 * `NUM_INPUTS - a - 1) / 2 + (b - a - 1);

				for (l = 0; l < `NUM_LAGS; l++) begin : g_lag
					// lag index l = c + LAG_CROSS - 1 is also the tap of channel b.
					assign next_products.hits[BASE * `NUM_LAGS + l] =
						tap_set.taps[a][`CENTRE_TAP] & tap_set.taps[b][l];
				end
			end
		end
	endgenerate

	assign next_products.valid = tap_set.valid;

	// ~~~~~~~~~~~~~~~~~~~~
	// output register

	always_ff @(posedge clk) begin
		if (!reset) begin
			products <= '0;
		end else begin
			products <= next_products;
		end
	end

endmodule

/* src/correlation_accum.sv */
/*
 * Saturating counter bank of the pulse correlator.
 * Each valid product adds one to every counter whose hit bit is set.
 * A counter at full scale holds its value and raises its saturated flag.
 * The clear pulse zeroes all counters and flags and wins over an increment
 * in the same cycle; later products count as normal.
 */

`include "correlator_consts.svh"

module correlation_accum (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         clear,
	input  correlator_pkg::product_t     products,
	output correlator_pkg::corr_count_t  counts [`NUM_CORR],
	output logic [`NUM_CORR-1:0]         saturated
);
	import correlator_pkg::*;

	localparam corr_count_t COUNT_MAX = '1;

	logic [`NUM_CORR-1:0] bump; // counters asked to step this cycle.

	assign bump = products.hits & {`NUM_CORR{products.valid}};

	// ~~~~~~~~~~~~~~~~~~~~
	// one counter per baseline and lag

	genvar i;
	generate
		for (i = 0; i < `NUM_CORR; i++) begin : g_counter
			logic at_max;

			assign at_max = (counts[i] == COUNT_MAX);

			always_ff @(posedge clk) begin
				if (!reset) begin
					counts[i] <= '0;
					saturated[i] <= 1'b0;
				end else if (clear) begin
					counts[i] <= '0; // product in this cycle is dropped.
					saturated[i] <= 1'b0;
				end else if (bump[i]) begin
					if (at_max) begin
						saturated[i] <= 1'b1; // count stays at full scale.
					end else begin
						counts[i] <= counts[i] + 1'b1;
					end
				end
			end
		end
	endgenerate

endmodule

/* src/correlator_pkg.sv */
/*
 * Types shared between the correlator pipeline stages.
 * Modules import this package in their bodies and name the port types
 * with scoped names in their headers.
 * Counter index order is baseline * NUM_LAGS + lag index, with baselines
 * numbered (0,1), (0,2), ... (N-2,N-1) and lag index c + LAG_CROSS - 1.
 */

`include "correlator_consts.svh"

package correlator_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// delay line to coincidence stage

	typedef struct packed {
		logic valid;
		logic [`NUM_INPUTS-1:0][`NUM_LAGS-1:0] taps; // tap 0 is newest.
	} tap_set_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// coincidence stage to accumulator

	typedef struct packed {
		logic valid;
		logic [`NUM_CORR-1:0] hits; // one bit per baseline and lag.
	} product_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// counters and readout

	typedef logic [`RESOLUTION-1:0] corr_count_t;

	typedef struct packed {
		logic saturated;
		corr_count_t count;
	} read_word_t;

endpackage

/* src/correlator_top.sv */
/*
 * Top level of the multi-channel pulse correlator.
 * Pulses are sampled on sample_strobe into per-channel delay lines, paired
 * per baseline and lag, and accumulated in saturating counters.
 * A counter reflects a strobe three cycles after the strobe edge, and
 * read_data follows read_addr by one cycle. There is no back-pressure.
 */

`include "correlator_consts.svh"

module correlator_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        sample_strobe,
	input  logic [`NUM_INPUTS-1:0]      samples,
	input  logic [`NUM_INPUTS-1:0]      channel_enable,
	input  logic                        clear,
	input  logic [`ADDR_WIDTH-1:0]      read_addr,
	output correlator_pkg::read_word_t  read_data
);
	import correlator_pkg::*;

	tap_set_t tap_set;
	product_t products;
	corr_count_t counts [`NUM_CORR];
	logic [`NUM_CORR-1:0] saturated;

	// ~~~~~~~~~~~~~~~~~~~~
	// pipeline

	lag_delay_line lag_delay_line_i (
		.clk            (clk),
		.reset          (reset),
		.sample_strobe  (sample_strobe),
		.samples        (samples),
		.channel_enable (channel_enable),
		.tap_set        (tap_set)
	);

	coincidence_stage coincidence_stage_i (
		.clk      (clk),
		.reset    (reset),
		.tap_set  (tap_set),
		.products (products)
	);

	correlation_accum correlation_accum_i (
		.clk       (clk),
		.reset     (reset),
		.clear     (clear),
		.products  (products),
		.counts    (counts),
		.saturated (saturated)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// readout

	readout_port readout_port_i (
		.clk       (clk),
		.reset     (reset),
		.read_addr (read_addr),
		.counts    (counts),
		.saturated (saturated),
		.read_data (read_data)
	);

endmodule

/* src/lag_delay_line.sv */
/*
 * Per-channel tapped shift registers for the pulse correlator.
 * On each sample strobe every channel shifts its history by one tap and
 * the new sample, masked by its channel enable, enters at tap 0.
 * The valid bit of the tap set is a registered copy of the strobe, so
 * the taps and valid change together one cycle after the strobe edge.
 */

`include "correlator_consts.svh"

module lag_delay_line (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      sample_strobe,
	input  logic [`NUM_INPUTS-1:0]    samples,
	input  logic [`NUM_INPUTS-1:0]    channel_enable,
	output correlator_pkg::tap_set_t  tap_set
);
	import correlator_pkg::*;

	logic [`NUM_INPUTS-1:0] gated; // disabled channels load as 0.
	tap_set_t shifted;

	assign gated = samples & channel_enable;

	// next tap set, held unless a strobe is present.
	always_comb begin
		shifted = tap_set;
		shifted.valid = sample_strobe;
		if (sample_strobe) begin
			for (int ch = 0; ch < `NUM_INPUTS; ch++) begin
				shifted.taps[ch] = {tap_set.taps[ch][`NUM_LAGS-2:0], gated[ch]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			tap_set <= '0;
		end else begin
			tap_set <= shifted;
		end
	end

endmodule

/* src/readout_port.sv */
/*
 * Registered read port for the correlation counters.
 * The addressed counter and its saturated flag appear on read_data one
 * cycle after read_addr. Addresses past the last counter read as zero.
 */

`include "correlator_consts.svh"

module readout_port (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [`ADDR_WIDTH-1:0]       read_addr,
	input  correlator_pkg::corr_count_t  counts [`NUM_CORR],
	input  logic [`NUM_CORR-1:0]         saturated,
	output correlator_pkg::read_word_t   read_data
);
	import correlator_pkg::*;

	localparam logic [`ADDR_WIDTH-1:0] LAST_ADDR = `ADDR_WIDTH'(`NUM_CORR - 1);

	read_word_t selected;

	always_comb begin
		selected = '0;
		if (read_addr <= LAST_ADDR) begin
			selected.saturated = saturated[read_addr];
			selected.count = counts[read_addr];
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			read_data <= '0;
		end else begin
			read_data <= selected;
		end
	end

endmodule
